// ==== lpi_axi_bridge.f ====
src/axi_bridge_pkg.sv
src/txn_track_if.sv
src/axi_req_issuer.sv
src/outstanding_tracker.sv
src/axi_resp_merger.sv
src/lpi_axi_bridge.sv
verification/lpi_axi_bridge_chk.sv
verification/axi_slave_model.sv
verification/lpi_axi_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module lpi_axi_bridge_tb \
	-f lpi_axi_bridge.f -o lpi_axi_bridge_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/lpi_axi_bridge_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
	exit 1
fi
exit 0

// ==== src/axi_bridge_pkg.sv ====
// ******************************
// Shared widths, vector types and
// state encodings of the request
// to AXI bridge
// ******************************

package axi_bridge_pkg;

	// ******************************
	// Widths and limits
	// ******************************

	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = DATA_WIDTH / 8;

	// Transactions allowed in flight at once
	localparam int MAX_OUTSTANDING = 4;

	// Count holds 0 up to MAX_OUTSTANDING inclusive
	localparam int CNT_WIDTH = $clog2(MAX_OUTSTANDING + 1);

	// ******************************
	// Vector types
	// ******************************

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [STRB_WIDTH-1:0] strb_t;

	// AXI AxSIZE encoding, bytes = 2**size
	typedef logic [2:0] size_t;

	// AXI response code, OKAY = 0, SLVERR = 2
	typedef logic [1:0] resp_t;

	typedef logic [CNT_WIDTH-1:0] cnt_t;

	// ******************************
	// State encodings
	// ******************************

	// Common direction of everything in flight
	typedef enum logic [1:0]
	{
		DIR_IDLE  = 2'd0,
		DIR_READ  = 2'd1,
		DIR_WRITE = 2'd2
	} track_dir_e;

	// Write sequencing, address phase then data phase
	typedef enum logic
	{
		PHASE_ADDR = 1'b0,
		PHASE_DATA = 1'b1
	} wr_phase_e;

endpackage

// ==== src/axi_req_issuer.sv ====
// ******************************
// Request issuer
// Drives AW, W and AR from the
// request port, sequences the
// write address and data phases
// ******************************

`timescale 1ns/100ps

module axi_req_issuer
	import axi_bridge_pkg::*;
(
	input  logic rvx_port_26,
	input  logic rvx_port_27,

	// Request port
	input  logic req_valid,
	input  logic req_write,
	input  addr_t req_addr,
	input  size_t req_size,
	input  strb_t req_strb,
	input  data_t req_wdata,
	output logic req_ready,

	// Tracking bundle
	txn_track_if.issuer track,

	// AXI write address
	output addr_t awaddr,
	output size_t awsize,
	output logic awvalid,
	input  logic awready,

	// AXI write data
	output data_t wdata,
	output strb_t wstrb,
	output logic wvalid,
	input  logic wready,

	// AXI read address
	output addr_t araddr,
	output size_t arsize,
	output logic arvalid,
	input  logic arready
);

	wr_phase_e wr_phase;
	logic aw_fire;
	logic w_fire;
	logic ar_fire;

	// ******************************
	// Channel valids
	// ******************************

	// AW only in the address phase and only with the tracker's consent
	assign awvalid = req_valid & req_write & track.allow_write & (wr_phase == PHASE_ADDR);

	// W follows once the address has been taken
	assign wvalid = req_valid & req_write & (wr_phase == PHASE_DATA);

	assign arvalid = req_valid & ~req_write & track.allow_read;

	assign aw_fire = awvalid & awready;
	assign w_fire = wvalid & wready;
	assign ar_fire = arvalid & arready;

	// Payloads follow the held request fields
	assign awaddr = req_addr;
	assign awsize = req_size;
	assign wdata = req_wdata;
	assign wstrb = req_strb;
	assign araddr = req_addr;
	assign arsize = req_size;

	// A write is taken on its data beat, a read on its address
	assign req_ready = req_write ? w_fire : ar_fire;

	assign track.aw_fire = aw_fire;
	assign track.ar_fire = ar_fire;

	// ******************************
	// Write phase register
	// ******************************

	always_ff @(posedge rvx_port_26 or negedge rvx_port_27)
	begin
		if (!rvx_port_27)
			wr_phase <= PHASE_ADDR;
		else if (aw_fire)
			wr_phase <= PHASE_DATA;
		else if (w_fire)
			wr_phase <= PHASE_ADDR;
	end

endmodule

// ==== src/axi_resp_merger.sv ====
// ******************************
// Response merger
// Folds B and R into the single
// response port
// ******************************

`timescale 1ns/100ps

module axi_resp_merger
	import axi_bridge_pkg::*;
(
	txn_track_if.merger track,

	// AXI write response
	input  resp_t bresp,
	input  logic bvalid,
	output logic bready,

	// AXI read data
	input  data_t rdata,
	input  resp_t rresp,
	input  logic rvalid,
	output logic rready,

	// Response port
	output logic resp_valid,
	output logic resp_write,
	output resp_t resp_code,
	output data_t resp_data,
	input  logic resp_ready
);

	logic dir_write;
	logic dir_read;
	logic b_pend;
	logic r_pend;

	assign dir_write = (track.dir == DIR_WRITE);
	assign dir_read = (track.dir == DIR_READ);

	// Only the channel matching the in-flight direction can be pending
	assign b_pend = bvalid & dir_write;
	assign r_pend = rvalid & dir_read;

	// ******************************
	// Response port
	// ******************************

	assign resp_valid = b_pend | r_pend;
	assign resp_write = b_pend;
	assign resp_code = b_pend ? bresp : rresp;

	// Writes carry no data back
	assign resp_data = r_pend ? rdata : '0;

	// Back-pressure goes to the expected channel only
	assign bready = resp_ready & dir_write;
	assign rready = resp_ready & dir_read;

	assign track.b_fire = bvalid & bready;
	assign track.r_fire = rvalid & rready;

endmodule

// ==== src/lpi_axi_bridge.sv ====
// ******************************
// Request port to AXI master
// bridge, top level
// ******************************

`timescale 1ns/100ps

module lpi_axi_bridge
	import axi_bridge_pkg::*;
(
	input  logic rvx_port_26,
	input  logic rvx_port_27,

	// Request port
	input  logic req_valid,
	input  logic req_write,
	input  addr_t req_addr,
	input  size_t req_size,
	input  strb_t req_strb,
	input  data_t req_wdata,
	output logic req_ready,

	// Response port
	output logic resp_valid,
	output logic resp_write,
	output resp_t resp_code,
	output data_t resp_data,
	input  logic resp_ready,

	// AXI AW and W
	output addr_t awaddr,
	output size_t awsize,
	output logic awvalid,
	input  logic awready,
	output data_t wdata,
	output strb_t wstrb,
	output logic wvalid,
	input  logic wready,

	// AXI B
	input  resp_t bresp,
	input  logic bvalid,
	output logic bready,

	// AXI AR and R
	output addr_t araddr,
	output size_t arsize,
	output logic arvalid,
	input  logic arready,
	input  data_t rdata,
	input  resp_t rresp,
	input  logic rvalid,
	output logic rready
);

	txn_track_if track_if ();

	axi_req_issuer issuer_i (
		.rvx_port_26 (rvx_port_26), .rvx_port_27 (rvx_port_27),
		.req_valid   (req_valid), .req_write (req_write), .req_addr (req_addr),
		.req_size    (req_size), .req_strb (req_strb), .req_wdata (req_wdata),
		.req_ready   (req_ready), .track (track_if.issuer),
		.awaddr (awaddr), .awsize (awsize), .awvalid (awvalid), .awready (awready),
		.wdata  (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
		.araddr (araddr), .arsize (arsize), .arvalid (arvalid), .arready (arready)
	);

	outstanding_tracker tracker_i (
		.rvx_port_26 (rvx_port_26), .rvx_port_27 (rvx_port_27),
		.track       (track_if.tracker)
	);

	axi_resp_merger merger_i (
		.track (track_if.merger),
		.bresp (bresp), .bvalid (bvalid), .bready (bready),
		.rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
		.resp_valid (resp_valid), .resp_write (resp_write), .resp_code (resp_code),
		.resp_data  (resp_data), .resp_ready (resp_ready)
	);

endmodule

// ==== src/outstanding_tracker.sv ====
// ******************************
// Outstanding transaction tracker
// In-flight counter, common
// direction and issue permissions
// ******************************

`timescale 1ns/100ps

module outstanding_tracker
	import axi_bridge_pkg::*;
(
	input  logic rvx_port_26,
	input  logic rvx_port_27,
	txn_track_if.tracker track
);

	cnt_t count;
	track_dir_e dir;
	logic cnt_up;
	logic cnt_down;
	logic cnt_zero;
	logic cnt_full;

	assign cnt_up = track.aw_fire | track.ar_fire;
	assign cnt_down = track.b_fire | track.r_fire;

	assign cnt_zero = (count == '0);
	assign cnt_full = (count >= cnt_t'(MAX_OUTSTANDING));

	// ******************************
	// Counter and direction
	// ******************************

	always_ff @(posedge rvx_port_26 or negedge rvx_port_27)
	begin
		if (!rvx_port_27)
			count <= '0;
		else if (cnt_up & ~cnt_down)
			count <= count + cnt_t'(1);
		else if (cnt_down & ~cnt_up)
			count <= count - cnt_t'(1);
	end

	always_ff @(posedge rvx_port_26 or negedge rvx_port_27)
	begin
		if (!rvx_port_27)
			dir <= DIR_IDLE;
		else if (cnt_zero & cnt_up)
			dir <= track.aw_fire ? DIR_WRITE : DIR_READ;
		// Last one out returns the tracker to idle
		else if (cnt_down & ~cnt_up & (count == cnt_t'(1)))
			dir <= DIR_IDLE;
	end

	// ******************************
	// Issue permissions
	// ******************************

	// Same direction may keep issuing until the cap, the other waits for drain
	assign track.allow_read = cnt_zero | ((dir == DIR_READ) & ~cnt_full);
	assign track.allow_write = cnt_zero | ((dir == DIR_WRITE) & ~cnt_full);

	assign track.dir = dir;

endmodule

// ==== src/txn_track_if.sv ====
// ******************************
// Transaction tracking bundle
// between issuer, tracker and
// response merger
// ******************************

`timescale 1ns/100ps

interface txn_track_if
	import axi_bridge_pkg::*;
();

	// Handshake events, one cycle each
	logic aw_fire;
	logic ar_fire;
	logic b_fire;
	logic r_fire;

	// Issue permissions and current direction
	logic allow_write;
	logic allow_read;
	track_dir_e dir;

	modport issuer (output aw_fire, output ar_fire, input allow_write, input allow_read);

	modport merger (output b_fire, output r_fire, input dir);

	modport tracker (
		input aw_fire, input ar_fire, input b_fire, input r_fire,
		output allow_write, output allow_read, output dir
	);

endinterface

// ==== verification/axi_slave_model.sv ====
// ******************************
// AXI slave memory model with
// random ready, response delays
// and in-order responses
// ******************************

`timescale 1ns/100ps

module axi_slave_model
	import axi_bridge_pkg::*;
#(
	parameter int SEED = 37
)
(
	input  logic rvx_port_26,
	input  logic rvx_port_27,
	input  addr_t awaddr,
	input  logic awvalid,
	output logic awready,
	input  data_t wdata,
	input  strb_t wstrb,
	input  logic wvalid,
	output logic wready,
	output resp_t bresp,
	output logic bvalid,
	input  logic bready,
	input  addr_t araddr,
	input  logic arvalid,
	output logic arready,
	output data_t rdata,
	output resp_t rresp,
	output logic rvalid,
	input  logic rready
);

	localparam addr_t ERR_BASE = 32'h8000_0000;

	logic [7:0] mem [addr_t];
	addr_t aw_q [$];
	logic rsp_write_q [$];
	resp_t rsp_code_q [$];
	data_t rsp_data_q [$];
	logic rsp_taken;
	int delay;
	integer seed;

	function automatic logic [7:0] mem_byte(addr_t a);
		if (mem.exists(a))
			return mem[a];
		return a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5a;
	endfunction

	// Write lands on the address taken earlier on AW
	function automatic void store_write();
		addr_t base;
		int i;
		base = awaddr;
		if (aw_q.size() != 0)
			base = aw_q.pop_front();
		for (i = 0; i < STRB_WIDTH; i++)
			if (base < ERR_BASE && wstrb[i])
				mem[{base[ADDR_WIDTH-1:2], 2'b00} + addr_t'(i)] = wdata[8*i +: 8];
		rsp_write_q.push_back(1'b1);
		rsp_code_q.push_back((base >= ERR_BASE) ? 2'd2 : 2'd0);
		rsp_data_q.push_back('0);
	endfunction

	function automatic void load_read();
		data_t d;
		int i;
		d = '0;
		for (i = 0; i < STRB_WIDTH; i++)
			if (araddr < ERR_BASE)
				d[8*i +: 8] = mem_byte({araddr[ADDR_WIDTH-1:2], 2'b00} + addr_t'(i));
		rsp_write_q.push_back(1'b0);
		rsp_code_q.push_back((araddr >= ERR_BASE) ? 2'd2 : 2'd0);
		rsp_data_q.push_back(d);
	endfunction

	initial
	begin
		seed = SEED;
		rsp_taken = 1'b0;
		delay = 0;
		awready = 1'b0;
		wready = 1'b0;
		arready = 1'b0;
		bvalid = 1'b0;
		rvalid = 1'b0;
		bresp = '0;
		rresp = '0;
		rdata = '0;
	end

	// Handshakes are taken on the rising edge
	always @(posedge rvx_port_26)
	begin
		if (rvx_port_27)
		begin
			if (awvalid && awready)
				aw_q.push_back(awaddr);
			if (wvalid && wready)
				store_write();
			if (arvalid && arready)
				load_read();
			if ((bvalid && bready) || (rvalid && rready))
				rsp_taken = 1'b1;
		end
	end

	// Outputs change on the falling edge
	always @(negedge rvx_port_26)
	begin
		if (!rvx_port_27)
		begin
			awready = 1'b0;
			wready = 1'b0;
			arready = 1'b0;
			bvalid = 1'b0;
			rvalid = 1'b0;
		end
		else
		begin
			awready = ({$random(seed)} % 4) != 0;
			wready = ({$random(seed)} % 4) != 0;
			arready = ({$random(seed)} % 4) != 0;
			if (rsp_taken)
			begin
				rsp_taken = 1'b0;
				bvalid = 1'b0;
				rvalid = 1'b0;
				rsp_write_q.delete(0);
				rsp_code_q.delete(0);
				rsp_data_q.delete(0);
				delay = int'({$random(seed)} % 4);
			end
			if (!bvalid && !rvalid && rsp_write_q.size() != 0)
			begin
				if (delay > 0)
					delay--;
				else
				begin
					bvalid = rsp_write_q[0];
					rvalid = !rsp_write_q[0];
					bresp = rsp_code_q[0];
					rresp = rsp_code_q[0];
					rdata = rsp_data_q[0];
				end
			end
		end
	end

endmodule

// ==== verification/lpi_axi_bridge_chk.sv ====
// ******************************
// Handshake assertions for the
// bridge AXI and response ports
// ******************************

`timescale 1ns/100ps

module lpi_axi_bridge_chk
	import axi_bridge_pkg::*;
(
	input  logic rvx_port_26,
	input  logic rvx_port_27,
	input  addr_t awaddr,
	input  size_t awsize,
	input  logic awvalid,
	input  logic awready,
	input  data_t wdata,
	input  strb_t wstrb,
	input  logic wvalid,
	input  logic wready,
	input  addr_t araddr,
	input  size_t arsize,
	input  logic arvalid,
	input  logic arready,
	input  logic resp_valid,
	input  logic resp_write,
	input  resp_t resp_code,
	input  data_t resp_data,
	input  logic resp_ready
);

	// Valid holds with a stable payload until ready
	aw_hold: assert property (@(posedge rvx_port_26) disable iff (!rvx_port_27)
		awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awsize))
		else $error("AW valid or payload changed before awready");

	w_hold: assert property (@(posedge rvx_port_26) disable iff (!rvx_port_27)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
		else $error("W valid or payload changed before wready");

	ar_hold: assert property (@(posedge rvx_port_26) disable iff (!rvx_port_27)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arsize))
		else $error("AR valid or payload changed before arready");

	resp_hold: assert property (@(posedge rvx_port_26) disable iff (!rvx_port_27)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp_write)
			&& $stable(resp_code) && $stable(resp_data))
		else $error("Response valid or fields changed before resp_ready");

endmodule

bind lpi_axi_bridge lpi_axi_bridge_chk chk_i (.*);

// ==== verification/lpi_axi_bridge_tb.sv ====
// ******************************
// Testbench for the request port
// to AXI bridge: seeded random
// requests, reference memory and
// in-order response checks
// ******************************

`timescale 1ns/100ps

module lpi_axi_bridge_tb
	import axi_bridge_pkg::*;
();

	localparam addr_t ERR_BOUNDARY = 32'h8000_0000;
	localparam int NUM_REQ = 300;
	localparam int TIMEOUT = 200;
	localparam int SEED = 37;
	localparam resp_t OKAY = 2'd0;
	localparam resp_t SLVERR = 2'd2;

	logic rvx_port_26;
	logic rvx_port_27;
	logic req_valid, req_write, req_ready;
	addr_t req_addr;
	size_t req_size;
	strb_t req_strb;
	data_t req_wdata;
	logic resp_valid, resp_write, resp_ready;
	resp_t resp_code;
	data_t resp_data;
	addr_t awaddr, araddr;
	size_t awsize, arsize;
	data_t wdata, rdata;
	strb_t wstrb;
	resp_t bresp, rresp;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;

	// Reference model and expected responses in request order
	logic [7:0] ref_mem [addr_t];
	logic exp_write [$];
	resp_t exp_code [$];
	data_t exp_data [$];
	integer seed;
	integer ready_seed;
	int errors;
	int resp_count;
	int gap;
	int n;
	logic timed_out;

	// Response seen stalled on the last edge
	logic held_valid, held_write;
	resp_t held_code;
	data_t held_data;

	lpi_axi_bridge lpi_axi_bridge_i (.*);

	axi_slave_model #(.SEED(SEED)) slave_i (.*);

	always #5 rvx_port_26 = ~rvx_port_26;

	// Random back-pressure on the response port
	always @(negedge rvx_port_26)
		resp_ready = rvx_port_27 && (({$random(ready_seed)} % 4) != 0);

	// ******************************
	// Model helpers
	// ******************************

	// Unwritten bytes read back a pattern of their address
	function automatic logic [7:0] ref_byte(addr_t a);
		if (ref_mem.exists(a))
			return ref_mem[a];
		return a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5a;
	endfunction

	function automatic void report_mismatch(string name, logic [31:0] expected,
		logic [31:0] actual);
		errors++;
		$display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
	endfunction

	function automatic void record_request();
		addr_t base;
		data_t rd;
		int i;
		base = {req_addr[ADDR_WIDTH-1:2], 2'b00};
		rd = '0;
		if (req_addr < ERR_BOUNDARY)
		begin
			for (i = 0; i < STRB_WIDTH; i++)
			begin
				if (req_write && req_strb[i])
					ref_mem[base + addr_t'(i)] = req_wdata[8*i +: 8];
				else if (!req_write)
					rd[8*i +: 8] = ref_byte(base + addr_t'(i));
			end
		end
		exp_write.push_back(req_write);
		exp_code.push_back((req_addr >= ERR_BOUNDARY) ? SLVERR : OKAY);
		exp_data.push_back(rd);
	endfunction

	function automatic void check_response();
		logic w;
		resp_t c;
		data_t d;
		resp_count++;
		if (exp_write.size() == 0)
		begin
			errors++;
			$display("Error at %0t: response arrived with no accepted request", $time);
		end
		else
		begin
			w = exp_write.pop_front();
			c = exp_code.pop_front();
			d = exp_data.pop_front();
			if (resp_write !== w)
				report_mismatch("resp_write", 32'(w), 32'(resp_write));
			if (resp_code !== c)
				report_mismatch("resp_code", 32'(c), 32'(resp_code));
			if (resp_data !== d)
				report_mismatch("resp_data", d, resp_data);
		end
	endfunction

	task automatic report_timeout(string what);
		errors++;
		$display("Timeout at %0t: %s", $time, what);
	endtask

	task automatic wait_accept(output logic expired);
		int cycles;
		cycles = 0;
		expired = 1'b0;
		@(posedge rvx_port_26);
		while (!req_ready && !expired)
		begin
			cycles++;
			if (cycles > TIMEOUT)
			begin
				report_timeout("request was never accepted");
				expired = 1'b1;
			end
			else
				@(posedge rvx_port_26);
		end
	endtask

	task automatic wait_drain(output logic expired);
		int cycles;
		cycles = 0;
		expired = 1'b0;
		while (exp_write.size() != 0 && !expired)
		begin
			cycles++;
			if (cycles > TIMEOUT)
			begin
				report_timeout("responses still outstanding at the end");
				expired = 1'b1;
			end
			else
				@(negedge rvx_port_26);
		end
	endtask

	// ******************************
	// Monitor
	// ******************************

	always @(posedge rvx_port_26)
	begin
		if (rvx_port_27)
		begin
			if (exp_write.size() > MAX_OUTSTANDING)
			begin
				errors++;
				$display("Error at %0t: more than four transactions in flight", $time);
			end
			if (exp_write.size() != 0 && exp_write[0] && arvalid)
			begin
				errors++;
				$display("Error at %0t: arvalid raised while writes are in flight", $time);
			end
			if (exp_write.size() != 0 && !exp_write[0] && awvalid)
			begin
				errors++;
				$display("Error at %0t: awvalid raised while reads are in flight", $time);
			end
			// Address channels carry the held request address and size
			if (awvalid && awready)
			begin
				if (awaddr !== req_addr)
					report_mismatch("awaddr", req_addr, awaddr);
				if (awsize !== req_size)
					report_mismatch("awsize", 32'(req_size), 32'(awsize));
			end
			if (arvalid && arready)
			begin
				if (araddr !== req_addr)
					report_mismatch("araddr", req_addr, araddr);
				if (arsize !== req_size)
					report_mismatch("arsize", 32'(req_size), 32'(arsize));
			end
			if (held_valid && (!resp_valid || resp_write !== held_write ||
				resp_code !== held_code || resp_data !== held_data))
			begin
				errors++;
				$display("Error at %0t: response changed while resp_ready was low", $time);
			end
			held_valid = resp_valid && !resp_ready;
			held_write = resp_write;
			held_code = resp_code;
			held_data = resp_data;
			if (resp_valid && resp_ready)
				check_response();
			if (req_valid && req_ready)
				record_request();
		end
	end

	// ******************************
	// Stimulus
	// ******************************

	initial
	begin
		seed = SEED;
		ready_seed = SEED;
		errors = 0;
		resp_count = 0;
		timed_out = 1'b0;
		held_valid = 1'b0;
		rvx_port_26 = 1'b0;
		rvx_port_27 = 1'b0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_size = '0;
		req_strb = '0;
		req_wdata = '0;
		resp_ready = 1'b0;
		repeat (2) @(posedge rvx_port_26);
		@(negedge rvx_port_26);
		rvx_port_27 = 1'b1;
		@(negedge rvx_port_26);

		// Idle outputs out of reset
		if (awvalid !== 1'b0)
			report_mismatch("awvalid", 32'd0, 32'(awvalid));
		if (wvalid !== 1'b0)
			report_mismatch("wvalid", 32'd0, 32'(wvalid));
		if (arvalid !== 1'b0)
			report_mismatch("arvalid", 32'd0, 32'(arvalid));
		if (req_ready !== 1'b0)
			report_mismatch("req_ready", 32'd0, 32'(req_ready));
		if (resp_valid !== 1'b0)
			report_mismatch("resp_valid", 32'd0, 32'(resp_valid));

		for (n = 0; n < NUM_REQ && !timed_out; n++)
		begin
			// Small word window so reads often hit earlier writes
			req_write = ({$random(seed)} % 2) == 0;
			req_addr = addr_t'(({$random(seed)} % 16) << 2);
			if (({$random(seed)} % 8) == 0)
				req_addr = req_addr | ERR_BOUNDARY;
			req_size = size_t'({$random(seed)} % 3);
			req_strb = strb_t'($random(seed));
			req_wdata = $random(seed);
			req_valid = 1'b1;
			wait_accept(timed_out);
			@(negedge rvx_port_26);
			req_valid = 1'b0;
			gap = int'({$random(seed)} % 4);
			repeat (gap) @(negedge rvx_port_26);
		end
		if (!timed_out)
			wait_drain(timed_out);

		$display("Requests %0d, responses %0d, errors %0d", NUM_REQ, resp_count, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule
